// ==== logic/mmu_config.svh ====
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// TLB geometry
`define _TLB_ENTRY_NUM      32
`define _TLB_IDX_WIDTH      $clog2(`_TLB_ENTRY_NUM)
`define _TLB_PORT           2

`define _PS_4K              6'd12               // Any other ps is a 4 MiB page
`define _ECODE_TLBR         32'h0000_003f       // Refill exception code

// TLBIDX
`define _TLBIDX_INDEX       4:0
`define _TLBIDX_PS          29:24
`define _TLBIDX_NE          31

// TLBEHI
`define _TLBEHI_VPPN        31:13

// TLBELO0 / TLBELO1
`define _TLBELO_TLB_V       0
`define _TLBELO_TLB_D       1
`define _TLBELO_TLB_PLV     3:2
`define _TLBELO_TLB_MAT     5:4
`define _TLBELO_TLB_G       6
`define _TLBELO_TLB_PPN_EN  27:8

// DMW0 / DMW1
`define _DMW_PSEG           27:25

`endif

// ==== logic/csr_pkg.sv ====
package csr_pkg;

    // Strobes from the decoder, one cycle wide
    typedef struct packed {
        logic tlbfill_en;
        logic tlbwr_en;
        logic invtlb_en;
    } decode_info_t;

    // CSR words read or written by TLB management instructions
    typedef struct packed {
        logic [31:0]      tlbidx;
        logic [31:0]      tlbehi;
        logic [1:0][31:0] tlbelo;       // Index 0 is TLBELO0
    } csr_tlb_img_t;

endpackage

// ==== logic/tlb_pkg.sv ====
`include "mmu_config.svh"

package tlb_pkg;

    // One half of an entry
    typedef struct packed {
        logic        v;
        logic        d;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic [19:0] ppn;
    } tlb_page_t;

    typedef struct packed {
        logic            e;
        logic [9:0]      asid;
        logic            g;
        logic [5:0]      ps;
        logic [18:0]     vppn;
        tlb_page_t [1:0] page;          // Even half at index 0
    } tlb_entry_t;

    typedef struct packed {
        logic [18:0] vppn;
        logic        odd_page;
        logic        fetch;
        logic [9:0]  asid;
    } tlb_s_req_t;

    typedef struct packed {
        logic                       found;
        logic [`_TLB_IDX_WIDTH-1:0] index;
        logic [5:0]                 ps;
        logic [19:0]                ppn;
        logic                       v;
        logic                       d;
        logic [1:0]                 mat;
        logic [1:0]                 plv;
    } tlb_s_resp_t;

    typedef struct packed {
        logic                       we;
        logic [`_TLB_IDX_WIDTH-1:0] index;
        tlb_entry_t                 entry;
    } tlb_w_req_t;

    typedef tlb_entry_t tlb_r_resp_t;

    typedef enum logic [4:0] {
        INVTLB_ALL0        = 5'd0,
        INVTLB_ALL1        = 5'd1,
        INVTLB_G           = 5'd2,
        INVTLB_NG          = 5'd3,
        INVTLB_NG_ASID     = 5'd4,
        INVTLB_NG_ASID_VA  = 5'd5,
        INVTLB_G_ASID_VA   = 5'd6
    } invtlb_op_e;

    typedef struct packed {
        logic        en;
        invtlb_op_e  op;
        logic [9:0]  asid;
        logic [18:0] vpn;
    } tlb_inv_req_t;

    typedef struct packed {
        logic [31:0] vaddr;
        logic        fetch;
        logic [9:0]  asid;
        logic        dmw0_en;
        logic        dmw1_en;
    } mmu_s_req_t;

    typedef struct packed {
        logic                       found;
        logic [`_TLB_IDX_WIDTH-1:0] index;
        logic [5:0]                 ps;
        logic [19:0]                ppn;
        logic                       v;
        logic                       d;
        logic [1:0]                 mat;
        logic [1:0]                 plv;
        logic [31:0]                paddr;
    } mmu_s_resp_t;

    // A 4 MiB page ignores the low vppn bits
    function automatic logic vppn_hit(tlb_entry_t ent, logic [18:0] vppn);
        if (ent.ps == `_PS_4K) begin
            return ent.vppn == vppn;
        end
        return ent.vppn[18:9] == vppn[18:9];
    endfunction

endpackage

// ==== logic/tlb_match.sv ====
`timescale 1ns/100ps
`include "mmu_config.svh"

module tlb_match (
    input  tlb_pkg::tlb_entry_t [`_TLB_ENTRY_NUM-1:0] entries_i,
    input  tlb_pkg::tlb_s_req_t                       req_i,
    output tlb_pkg::tlb_s_resp_t                      resp_o
);

    import tlb_pkg::*;

    logic [`_TLB_ENTRY_NUM-1:0] hit;
    logic [`_TLB_IDX_WIDTH-1:0] hit_idx;
    tlb_entry_t                 hit_ent;
    logic                       odd;
    tlb_page_t                  page;

    for (genvar i = 0; i < `_TLB_ENTRY_NUM; i++) begin : g_cmp
        assign hit[i] = entries_i[i].e
                     && (entries_i[i].g || entries_i[i].asid == req_i.asid)
                     && vppn_hit(entries_i[i], req_i.vppn);
    end

    // Lowest index wins
    always_comb begin
        hit_idx = '0;
        for (int i = `_TLB_ENTRY_NUM - 1; i >= 0; i--) begin
            if (hit[i]) begin
                hit_idx = i[`_TLB_IDX_WIDTH-1:0];
            end
        end
    end

    assign hit_ent = entries_i[hit_idx];
    assign odd     = (hit_ent.ps == `_PS_4K) ? req_i.odd_page : req_i.vppn[8];  // vaddr[21]
    assign page    = hit_ent.page[odd];

    always_comb begin
        resp_o = '0;
        if (|hit) begin
            resp_o.found = 1'b1;
            resp_o.index = hit_idx;
            resp_o.ps    = hit_ent.ps;
            resp_o.ppn   = page.ppn;
            resp_o.v     = page.v;
            resp_o.d     = page.d;
            resp_o.mat   = page.mat;
            resp_o.plv   = page.plv;
        end
    end

endmodule

// ==== logic/tlb.sv ====
`timescale 1ns/100ps
`include "mmu_config.svh"

module tlb (
    input  logic                                    clk,
    input  logic                                    rst_n_i,

    input  tlb_pkg::tlb_s_req_t                     s_instr_req_i,
    output tlb_pkg::tlb_s_resp_t                    s_instr_resp_o,
    input  tlb_pkg::tlb_s_req_t  [`_TLB_PORT-1:0]   s_data_req_i,
    output tlb_pkg::tlb_s_resp_t [`_TLB_PORT-1:0]   s_data_resp_o,

    input  tlb_pkg::tlb_w_req_t                     w_req_i,
    input  logic [`_TLB_IDX_WIDTH-1:0]              r_index_i,
    output tlb_pkg::tlb_r_resp_t                    r_resp_o,
    input  tlb_pkg::tlb_inv_req_t                   inv_req_i
);

    import tlb_pkg::*;

    tlb_entry_t  [`_TLB_ENTRY_NUM-1:0] entry_q;
    logic        [`_TLB_ENTRY_NUM-1:0] inv_hit;
    logic        [`_TLB_ENTRY_NUM-1:0] asid_eq;
    logic        [`_TLB_ENTRY_NUM-1:0] vppn_eq;

    tlb_s_req_t  [`_TLB_PORT:0]        s_req;
    tlb_s_resp_t [`_TLB_PORT:0]        s_resp;

    // INVTLB select, all entries in parallel
    always_comb begin
        for (int i = 0; i < `_TLB_ENTRY_NUM; i++) begin
            asid_eq[i] = entry_q[i].asid == inv_req_i.asid;
            vppn_eq[i] = vppn_hit(entry_q[i], inv_req_i.vpn);
            case (inv_req_i.op)
                INVTLB_ALL0,
                INVTLB_ALL1: begin
                    inv_hit[i] = 1'b1;
                end
                INVTLB_G: begin
                    inv_hit[i] = entry_q[i].g;
                end
                INVTLB_NG: begin
                    inv_hit[i] = !entry_q[i].g;
                end
                INVTLB_NG_ASID: begin
                    inv_hit[i] = !entry_q[i].g && asid_eq[i];
                end
                INVTLB_NG_ASID_VA: begin
                    inv_hit[i] = !entry_q[i].g && asid_eq[i] && vppn_eq[i];
                end
                INVTLB_G_ASID_VA: begin
                    inv_hit[i] = (entry_q[i].g || asid_eq[i]) && vppn_eq[i];
                end
                default: begin
                    inv_hit[i] = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `_TLB_ENTRY_NUM; i++) begin
                entry_q[i].e <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `_TLB_ENTRY_NUM; i++) begin
                if (inv_req_i.en && inv_hit[i]) begin
                    entry_q[i].e <= 1'b0;
                end
            end
            if (w_req_i.we) begin
                entry_q[w_req_i.index] <= w_req_i.entry;   // Overrides a same-cycle invalidate
            end
        end
    end

    assign r_resp_o = entry_q[r_index_i];

    // Instruction port sits on the top slot
    assign s_req          = {s_instr_req_i, s_data_req_i};
    assign s_data_resp_o  = s_resp[`_TLB_PORT-1:0];
    assign s_instr_resp_o = s_resp[`_TLB_PORT];

    for (genvar p = 0; p <= `_TLB_PORT; p++) begin : g_port
        tlb_match tlb_match_inst (
            .entries_i (entry_q),
            .req_i     (s_req[p]),
            .resp_o    (s_resp[p])
        );
    end

endmodule

// ==== logic/mmu.sv ====
`timescale 1ns/100ps
`include "mmu_config.svh"

module mmu (
    input  logic                                    clk,
    input  logic                                    rst_n_i,

    input  logic                                    mmu_instr_trans_en_i,
    input  logic                 [`_TLB_PORT-1:0]   mmu_data_trans_en_i,
    input  tlb_pkg::mmu_s_req_t                     mmu_s_instr_req_i,
    output tlb_pkg::mmu_s_resp_t                    mmu_s_instr_resp_o,
    input  tlb_pkg::mmu_s_req_t  [`_TLB_PORT-1:0]   mmu_s_data_req_i,
    output tlb_pkg::mmu_s_resp_t [`_TLB_PORT-1:0]   mmu_s_data_resp_o,

    input  csr_pkg::decode_info_t                   decode_info_i,
    input  logic [25:0]                             instr_i,

    input  logic [`_TLB_IDX_WIDTH-1:0]              rand_index_i,
    input  logic [31:0]                             tlbehi_i,
    input  logic [31:0]                             tlbelo0_i,
    input  logic [31:0]                             tlbelo1_i,
    input  logic [31:0]                             tlbidx_i,
    input  logic [31:0]                             ecode_i,

    output logic [31:0]                             tlbehi_o,
    output logic [31:0]                             tlbelo0_o,
    output logic [31:0]                             tlbelo1_o,
    output logic [31:0]                             tlbidx_o,
    output logic [9:0]                              asid_o,

    input  logic [9:0]                              invtlb_asid_i,
    input  logic [18:0]                             invtlb_vpn_i,

    input  logic [31:0]                             csr_dmw0_i,
    input  logic [31:0]                             csr_dmw1_i,
    input  logic                                    csr_da_i,
    input  logic                                    csr_pg_i
);

    import tlb_pkg::*;
    import csr_pkg::*;

    mmu_s_req_t  [`_TLB_PORT:0] req_all;
    mmu_s_resp_t [`_TLB_PORT:0] resp_all;
    logic        [`_TLB_PORT:0] trans_en;
    tlb_s_req_t  [`_TLB_PORT:0] tlb_req;
    tlb_s_resp_t [`_TLB_PORT:0] tlb_resp;

    tlb_s_req_t  [`_TLB_PORT-1:0] tlb_s_data_req;
    tlb_s_resp_t [`_TLB_PORT-1:0] tlb_s_data_resp;
    tlb_s_req_t                   tlb_s_instr_req;
    tlb_s_resp_t                  tlb_s_instr_resp;

    tlb_w_req_t   tlb_w_req;
    tlb_r_resp_t  tlb_r_resp;
    tlb_inv_req_t tlb_inv_req;
    csr_tlb_img_t wr_img;
    csr_tlb_img_t rd_img;
    logic         pg_mode;

    assign wr_img = '{tlbidx: tlbidx_i, tlbehi: tlbehi_i, tlbelo: {tlbelo1_i, tlbelo0_i}};

    // TLBFILL / TLBWR request
    always_comb begin
        tlb_w_req.we         = decode_info_i.tlbfill_en || decode_info_i.tlbwr_en;
        tlb_w_req.index      = decode_info_i.tlbfill_en ? rand_index_i
                                                        : wr_img.tlbidx[`_TLBIDX_INDEX];
        tlb_w_req.entry.e    = (ecode_i == `_ECODE_TLBR) || !wr_img.tlbidx[`_TLBIDX_NE];
        tlb_w_req.entry.asid = mmu_s_instr_req_i.asid;     // Current ASID
        tlb_w_req.entry.g    = wr_img.tlbelo[0][`_TLBELO_TLB_G] && wr_img.tlbelo[1][`_TLBELO_TLB_G];
        tlb_w_req.entry.ps   = wr_img.tlbidx[`_TLBIDX_PS];
        tlb_w_req.entry.vppn = wr_img.tlbehi[`_TLBEHI_VPPN];
        for (int j = 0; j < 2; j++) begin
            tlb_w_req.entry.page[j].v   = wr_img.tlbelo[j][`_TLBELO_TLB_V];
            tlb_w_req.entry.page[j].d   = wr_img.tlbelo[j][`_TLBELO_TLB_D];
            tlb_w_req.entry.page[j].plv = wr_img.tlbelo[j][`_TLBELO_TLB_PLV];
            tlb_w_req.entry.page[j].mat = wr_img.tlbelo[j][`_TLBELO_TLB_MAT];
            tlb_w_req.entry.page[j].ppn = wr_img.tlbelo[j][`_TLBELO_TLB_PPN_EN];
        end
    end

    // TLBRD read-back, index field reads as zero
    always_comb begin
        rd_img                      = '0;
        rd_img.tlbidx[`_TLBIDX_NE]  = !tlb_r_resp.e;
        rd_img.tlbidx[`_TLBIDX_PS]  = tlb_r_resp.ps;
        rd_img.tlbehi[`_TLBEHI_VPPN] = tlb_r_resp.vppn;
        for (int j = 0; j < 2; j++) begin
            rd_img.tlbelo[j][`_TLBELO_TLB_V]      = tlb_r_resp.page[j].v;
            rd_img.tlbelo[j][`_TLBELO_TLB_D]      = tlb_r_resp.page[j].d;
            rd_img.tlbelo[j][`_TLBELO_TLB_PLV]    = tlb_r_resp.page[j].plv;
            rd_img.tlbelo[j][`_TLBELO_TLB_MAT]    = tlb_r_resp.page[j].mat;
            rd_img.tlbelo[j][`_TLBELO_TLB_G]      = tlb_r_resp.g;
            rd_img.tlbelo[j][`_TLBELO_TLB_PPN_EN] = tlb_r_resp.page[j].ppn;
        end
    end

    assign tlbidx_o  = rd_img.tlbidx;
    assign tlbehi_o  = rd_img.tlbehi;
    assign tlbelo0_o = rd_img.tlbelo[0];
    assign tlbelo1_o = rd_img.tlbelo[1];
    assign asid_o    = tlb_r_resp.asid;

    assign tlb_inv_req.en   = decode_info_i.invtlb_en;
    assign tlb_inv_req.op   = invtlb_op_e'(instr_i[4:0]);
    assign tlb_inv_req.asid = invtlb_asid_i;
    assign tlb_inv_req.vpn  = invtlb_vpn_i;

    assign pg_mode = !csr_da_i && csr_pg_i;

    // Instruction port on the top slot
    assign req_all            = {mmu_s_instr_req_i, mmu_s_data_req_i};
    assign trans_en           = {mmu_instr_trans_en_i, mmu_data_trans_en_i};
    assign tlb_s_instr_req    = tlb_req[`_TLB_PORT];
    assign tlb_s_data_req     = tlb_req[`_TLB_PORT-1:0];
    assign tlb_resp           = {tlb_s_instr_resp, tlb_s_data_resp};
    assign mmu_s_instr_resp_o = resp_all[`_TLB_PORT];
    assign mmu_s_data_resp_o  = resp_all[`_TLB_PORT-1:0];

    for (genvar p = 0; p <= `_TLB_PORT; p++) begin : g_port
        assign tlb_req[p].vppn     = req_all[p].vaddr[31:13];
        assign tlb_req[p].odd_page = req_all[p].vaddr[12];
        assign tlb_req[p].fetch    = req_all[p].fetch;
        assign tlb_req[p].asid     = req_all[p].asid;

        always_comb begin
            resp_all[p].found = tlb_resp[p].found;
            resp_all[p].index = tlb_resp[p].index;
            resp_all[p].ps    = tlb_resp[p].ps;
            resp_all[p].ppn   = tlb_resp[p].ppn;
            resp_all[p].v     = tlb_resp[p].v;
            resp_all[p].d     = tlb_resp[p].d;
            resp_all[p].mat   = tlb_resp[p].mat;
            resp_all[p].plv   = tlb_resp[p].plv;

            resp_all[p].paddr = req_all[p].vaddr;
            if (pg_mode && req_all[p].dmw0_en) begin
                resp_all[p].paddr = {csr_dmw0_i[`_DMW_PSEG], req_all[p].vaddr[28:0]};
            end else if (pg_mode && req_all[p].dmw1_en) begin
                resp_all[p].paddr = {csr_dmw1_i[`_DMW_PSEG], req_all[p].vaddr[28:0]};
            end

            if (trans_en[p]) begin
                if (tlb_resp[p].ps == `_PS_4K) begin
                    resp_all[p].paddr[31:12] = tlb_resp[p].ppn;
                end else begin
                    resp_all[p].paddr[31:12] = {tlb_resp[p].ppn[19:10], req_all[p].vaddr[21:12]};
                end
            end
        end
    end

    tlb tlb_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .s_instr_req_i  (tlb_s_instr_req),
        .s_instr_resp_o (tlb_s_instr_resp),
        .s_data_req_i   (tlb_s_data_req),
        .s_data_resp_o  (tlb_s_data_resp),
        .w_req_i        (tlb_w_req),
        .r_index_i      (wr_img.tlbidx[`_TLBIDX_INDEX]),
        .r_resp_o       (tlb_r_resp),
        .inv_req_i      (tlb_inv_req)
    );

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = !clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        #1 rst_n_o = 1'b1;          // Same offset as the stimulus
    end

endmodule

// ==== dv/mmu_tb_model.svh ====
`ifndef MMU_TB_MODEL_SVH
`define MMU_TB_MODEL_SVH

logic [31:0] lfsr_q = 32'hfae7_28dd;
tlb_entry_t  model_tlb [`_TLB_ENTRY_NUM];
logic        model_known [`_TLB_ENTRY_NUM] = '{default: 1'b0};    // Entry written at least once
int          err_count = 0;

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        r      = {r[30:0], fb};
    end
    return r;
endfunction

function automatic logic vppn_match(tlb_entry_t ent, logic [18:0] vppn);
    return (ent.ps == 6'd12) ? (ent.vppn == vppn) : (ent.vppn[18:9] == vppn[18:9]);
endfunction

function automatic tlb_page_t elo_to_page(logic [31:0] elo);
    return '{v: elo[0], d: elo[1], plv: elo[3:2], mat: elo[5:4], ppn: elo[27:8]};
endfunction

function automatic logic [31:0] page_to_elo(tlb_page_t pg, logic g);
    return {4'h0, pg.ppn, 1'b0, g, pg.mat, pg.plv, pg.d, pg.v};
endfunction

function automatic void record_write();
    logic [4:0] idx;
    idx = decode_info_i.tlbfill_en ? rand_index_i : tlbidx_i[4:0];
    model_known[idx]       = 1'b1;
    model_tlb[idx].e       = (ecode_i == 32'h3f) || !tlbidx_i[31];
    model_tlb[idx].asid    = mmu_s_instr_req_i.asid;
    model_tlb[idx].g       = tlbelo0_i[6] && tlbelo1_i[6];
    model_tlb[idx].ps      = tlbidx_i[29:24];
    model_tlb[idx].vppn    = tlbehi_i[31:13];
    model_tlb[idx].page[0] = elo_to_page(tlbelo0_i);
    model_tlb[idx].page[1] = elo_to_page(tlbelo1_i);
endfunction

function automatic void apply_invalidate();
    logic g;
    logic asid_eq;
    logic va_eq;
    logic kill;
    for (int i = 0; i < `_TLB_ENTRY_NUM; i++) begin
        g       = model_tlb[i].g;
        asid_eq = model_tlb[i].asid == invtlb_asid_i;
        va_eq   = vppn_match(model_tlb[i], invtlb_vpn_i);
        case (instr_i[4:0])
            5'd0, 5'd1: kill = 1'b1;
            5'd2:       kill = g;
            5'd3:       kill = !g;
            5'd4:       kill = !g && asid_eq;
            5'd5:       kill = !g && asid_eq && va_eq;
            5'd6:       kill = (g || asid_eq) && va_eq;
            default:    kill = 1'b0;
        endcase
        if (model_known[i] && kill) begin
            model_tlb[i].e = 1'b0;
        end
    end
endfunction

function automatic mmu_s_resp_t expected_resp(mmu_s_req_t req, logic trans_en);
    mmu_s_resp_t rsp;
    tlb_entry_t  ent;
    tlb_page_t   pg;
    rsp = '0;
    for (int i = `_TLB_ENTRY_NUM - 1; i >= 0; i--) begin     // Lowest index wins
        ent = model_tlb[i];
        if (model_known[i] && ent.e && (ent.g || ent.asid == req.asid)
                && vppn_match(ent, req.vaddr[31:13])) begin
            pg        = ent.page[(ent.ps == 6'd12) ? req.vaddr[12] : req.vaddr[21]];
            rsp.found = 1'b1;
            rsp.index = 5'(i);
            rsp.ps    = ent.ps;
            rsp.ppn   = pg.ppn;
            rsp.v     = pg.v;
            rsp.d     = pg.d;
            rsp.mat   = pg.mat;
            rsp.plv   = pg.plv;
        end
    end
    rsp.paddr = req.vaddr;
    if (!csr_da_i && csr_pg_i && req.dmw0_en) begin
        rsp.paddr[31:29] = csr_dmw0_i[27:25];
    end else if (!csr_da_i && csr_pg_i && req.dmw1_en) begin
        rsp.paddr[31:29] = csr_dmw1_i[27:25];
    end
    if (trans_en) begin
        rsp.paddr[31:12] = (rsp.ps == 6'd12) ? rsp.ppn : {rsp.ppn[19:10], req.vaddr[21:12]};
    end
    return rsp;
endfunction

task automatic check_value(string name, logic [127:0] got, logic [127:0] exp);
    if (got !== exp) begin
        err_count++;
        $display("error at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
    end
endtask

`endif

// ==== dv/mmu_tb.sv ====
`timescale 1ns/100ps
`include "mmu_config.svh"

module mmu_tb;

    import tlb_pkg::*;
    import csr_pkg::*;

    logic                                 clk;
    logic                                 rst_n_i;
    logic                                 mmu_instr_trans_en_i;
    logic                [`_TLB_PORT-1:0] mmu_data_trans_en_i;
    mmu_s_req_t                           mmu_s_instr_req_i;
    mmu_s_resp_t                          mmu_s_instr_resp_o;
    mmu_s_req_t          [`_TLB_PORT-1:0] mmu_s_data_req_i;
    mmu_s_resp_t         [`_TLB_PORT-1:0] mmu_s_data_resp_o;
    decode_info_t                         decode_info_i;
    logic [25:0] instr_i;
    logic [4:0]  rand_index_i;
    logic [31:0] tlbehi_i;
    logic [31:0] tlbelo0_i;
    logic [31:0] tlbelo1_i;
    logic [31:0] tlbidx_i;
    logic [31:0] ecode_i;
    logic [31:0] tlbehi_o;
    logic [31:0] tlbelo0_o;
    logic [31:0] tlbelo1_o;
    logic [31:0] tlbidx_o;
    logic [9:0]  asid_o;
    logic [9:0]  invtlb_asid_i;
    logic [18:0] invtlb_vpn_i;
    logic [31:0] csr_dmw0_i;
    logic [31:0] csr_dmw1_i;
    logic        csr_da_i;
    logic        csr_pg_i;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errs_before = 0;

    `include "mmu_tb_model.svh"

    tb_clock_gen clock_gen_inst (.clk_o(clk), .rst_n_o(rst_n_i));

    mmu mmu_inst (.*);

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_inputs();
        mmu_instr_trans_en_i = 1'b0;
        mmu_data_trans_en_i  = '0;
        mmu_s_instr_req_i    = '0;
        mmu_s_data_req_i     = '0;
        decode_info_i        = '0;
        instr_i              = '0;
        rand_index_i         = '0;
        tlbehi_i             = '0;
        tlbelo0_i            = '0;
        tlbelo1_i            = '0;
        tlbidx_i             = '0;
        ecode_i              = '0;
        invtlb_asid_i        = '0;
        invtlb_vpn_i         = '0;
        csr_dmw0_i           = '0;
        csr_dmw1_i           = '0;
        csr_da_i             = 1'b0;
        csr_pg_i             = 1'b0;
    endtask

    task automatic wait_reset(output logic ok);
        ok = 1'b0;
        for (int i = 0; i < 100 && !ok; i++) begin
            @(posedge clk);
            ok = rst_n_i;
        end
        #1;
    endtask

    function automatic mmu_s_req_t random_req();
        mmu_s_req_t r;
        logic [4:0] k;
        k       = 5'(rand_bits(5));
        r       = '0;
        r.vaddr = rand_bits(32);
        if (model_known[k] && rand_bits(2) != 0) begin     // Aim at a loaded page
            r.vaddr[31:13] = model_tlb[k].vppn;
            if (model_tlb[k].ps != 6'd12) begin
                r.vaddr[21] = 1'(rand_bits(1));
            end
        end
        r.fetch   = 1'(rand_bits(1));
        r.asid    = 10'(rand_bits(1)) + 10'd1;
        r.dmw0_en = 1'(rand_bits(1));
        r.dmw1_en = 1'(rand_bits(1));
        return r;
    endfunction

    task automatic drive_search(logic use_tlb);
        mmu_s_instr_req_i    = random_req();
        mmu_instr_trans_en_i = use_tlb && rand_bits(1) != 0;
        for (int p = 0; p < `_TLB_PORT; p++) begin
            mmu_s_data_req_i[p]    = random_req();
            mmu_data_trans_en_i[p] = use_tlb && rand_bits(1) != 0;
        end
        tlbidx_i[4:0] = 5'(rand_bits(5));                   // Read index
        next_cycle();
    endtask

    // One TLBFILL or TLBWR pulse and a read-back cycle at that index
    task automatic write_entry(logic fill, logic [4:0] idx, logic ne, logic [31:0] ecode);
        logic [5:0] ps;
        logic [4:0] other;
        ps                       = rand_bits(1) != 0 ? 6'd12 : 6'd21;
        other                    = ~idx;
        tlbehi_i                 = {3'(rand_bits(3)), 7'h55, 22'(rand_bits(22))};
        tlbelo0_i                = rand_bits(32);
        tlbelo1_i                = rand_bits(32);
        tlbidx_i[31:5]           = {ne, 1'(rand_bits(1)), ps, 19'(rand_bits(19))};
        tlbidx_i[4:0]            = fill ? other : idx;     // Unused index source points away
        rand_index_i             = fill ? idx : other;
        ecode_i                  = ecode;
        mmu_s_instr_req_i.asid   = 10'(rand_bits(1)) + 10'd1;
        decode_info_i.tlbfill_en = fill;
        decode_info_i.tlbwr_en   = !fill;
        next_cycle();
        decode_info_i = '0;
        tlbidx_i[4:0] = idx;
        next_cycle();
    endtask

    task automatic fill_table();
        for (int i = 0; i < `_TLB_ENTRY_NUM; i++) begin
            write_entry(1'b1, 5'(i), 1'b0, 32'h0);
        end
    endtask

    task automatic compare_outputs();
        logic [4:0] ri;
        ri = tlbidx_i[4:0];
        check_value("mmu_s_instr_resp_o", mmu_s_instr_resp_o,
                    expected_resp(mmu_s_instr_req_i, mmu_instr_trans_en_i));
        for (int p = 0; p < `_TLB_PORT; p++) begin
            check_value($sformatf("mmu_s_data_resp_o[%0d]", p), mmu_s_data_resp_o[p],
                        expected_resp(mmu_s_data_req_i[p], mmu_data_trans_en_i[p]));
        end
        if (model_known[ri]) begin
            check_value("tlbidx_o", tlbidx_o, {!model_tlb[ri].e, 1'b0, model_tlb[ri].ps, 24'h0});
            check_value("tlbehi_o", tlbehi_o, {model_tlb[ri].vppn, 13'h0});
            check_value("tlbelo0_o", tlbelo0_o, page_to_elo(model_tlb[ri].page[0], model_tlb[ri].g));
            check_value("tlbelo1_o", tlbelo1_o, page_to_elo(model_tlb[ri].page[1], model_tlb[ri].g));
            check_value("asid_o", asid_o, model_tlb[ri].asid);
        end else begin
            check_value("tlbidx_o[31]", tlbidx_o[31], 1'b1);   // Never written so e is clear
        end
    endtask

    task automatic report_test(string name);
        tests_run++;
        if (err_count != errs_before) begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name, err_count - errs_before);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        errs_before = err_count;
    endtask

    // Model steps after the compare and the DUT at the coming edge
    always begin
        @(posedge clk);
        #9;
        if (rst_n_i) begin
            compare_outputs();
            if (decode_info_i.invtlb_en) begin
                apply_invalidate();
            end
            if (decode_info_i.tlbfill_en || decode_info_i.tlbwr_en) begin
                record_write();
            end
        end
    end

    initial begin
        logic ok;
        idle_inputs();
        wait_reset(ok);
        if (!ok) begin
            $display("reset was never released");
            $display(">>> FAIL");
            $finish;
        end else begin
            csr_pg_i = 1'b1;
            repeat (20) drive_search(1'b1);
            report_test("empty tlb");

            csr_da_i = 1'b1;
            csr_pg_i = 1'b0;
            repeat (20) drive_search(1'b0);
            csr_da_i   = 1'b0;
            csr_pg_i   = 1'b1;
            csr_dmw0_i = rand_bits(32);
            csr_dmw1_i = rand_bits(32);
            csr_dmw1_i[27:25] = ~csr_dmw0_i[27:25];         // Distinct windows show which wins
            repeat (30) drive_search(1'b0);
            report_test("direct and dmw");

            repeat (8) write_entry(1'b1, 5'(rand_bits(5)), 1'(rand_bits(1)), 32'h0);
            for (int i = 0; i < 8; i++) begin
                write_entry(1'b0, 5'(i * 4 + 1), 1'(rand_bits(1)), 32'h0);
            end
            repeat (4) write_entry(1'b0, 5'(rand_bits(5)), 1'b1, 32'h3f);   // Refill ignores NE
            report_test("write and read");

            fill_table();
            repeat (60) drive_search(1'b1);
            report_test("translate");

            for (int op = 0; op < 8; op++) begin
                fill_table();
                instr_i                 = {21'(rand_bits(21)), 5'(op)};
                invtlb_asid_i           = 10'(rand_bits(1)) + 10'd1;
                invtlb_vpn_i            = model_tlb[5'(rand_bits(5))].vppn;
                decode_info_i.invtlb_en = 1'b1;
                next_cycle();
                decode_info_i.invtlb_en = 1'b0;
                repeat (20) drive_search(1'b1);
            end
            report_test("invtlb");

            $display("summary: %0d tests, %0d failed, %0d errors",
                     tests_run, tests_failed, err_count);
            if (tests_failed == 0 && err_count == 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

// ==== files.f ====
+incdir+logic
+incdir+dv
logic/csr_pkg.sv
logic/tlb_pkg.sv
logic/tlb_match.sv
logic/tlb.sv
logic/mmu.sv
dv/tb_clock_gen.sv
dv/mmu_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= mmu_tb
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
FLAGS      ?= --binary --timing -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)
LINT_FLAGS ?= --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

# The run passes only if the testbench printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx '>>> PASS'

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
